//--- Makefile
# Verilator build and run of the opcode decoder testbench

VERILATOR ?= verilator
TOP       ?= op_decode_tb
SEED      ?= 1742859656
FLIST     ?= project.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP SEED FLIST OBJ_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -GSEED=$(SEED) -Mdir $(OBJ_DIR) -f $(FLIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "TESTBENCH PASSED"

clean:
	rm -rf $(OBJ_DIR)

//--- logic/dec_pkg.sv
// opcode word union with stack and immediate field views
`include "dec_settings.svh"

package dec_pkg;

	// stack view, low bits select and pop the operand stacks
	typedef struct packed {
		logic [`DEC_OPF_W-1:0]     op;      // op field, opcode[15:6]
		logic                      b_pop;   // pop b stack
		logic                      a_pop;   // pop a stack
		logic [`DEC_STK_W-1:0]     b_sel;   // b stack select
		logic [`DEC_STK_W-1:0]     a_sel;   // a stack select
	} op_stk_s;

	// immediate view, byte sits at opcode[13:6]
	typedef struct packed {
		logic [1:0]                grp;     // top group bits
		logic [`DEC_IM_DATA_W-1:0] im;      // immediate byte
		logic [5:0]                lo6;     // stack control bits
	} op_imm_s;

	typedef union packed {
		op_stk_s stk;
		op_imm_s imm;
	} op_word_u;

endpackage

//--- logic/dec_settings.svh
// decoder widths, stack count, register stage counts and opcode encoding constants
`ifndef DEC_SETTINGS_SVH
`define DEC_SETTINGS_SVH

`define DEC_OP_W       16   // opcode width
`define DEC_OPF_W      10   // op field width, opcode[15:6]
`define DEC_STACKS     4    // number of stacks
`define DEC_STK_W      2    // stack selector width
`define DEC_IM_DATA_W  8    // immediate data width
`define DEC_IM_ADDR_W  5    // immediate address width
`define DEC_LG_W       2    // logic op select width
`define DEC_REGS_IN    1    // input register stages
`define DEC_REGS_OUT   1    // output register stages

// op field groups, casez patterns over opcode[15:6]
`define DEC_GRP_BYT    10'b01????????   // push byte immediate
`define DEC_GRP_JMPI   10'b10????????   // conditional jump, immediate offset
`define DEC_GRP_ADDI   10'b1100??????   // add signed 6 bit immediate
`define DEC_GRP_JMP    10'b1110000???   // conditional jump, register offset
`define DEC_GRP_GTO    10'b1110001???   // conditional goto, register address
`define DEC_GRP_SGL    10'b111100????   // singles, code in op[3:0]

// single codes
`define DEC_SGL_ADD    4'd0
`define DEC_SGL_SUB    4'd1
`define DEC_SGL_AND    4'd2
`define DEC_SGL_OR     4'd3
`define DEC_SGL_XOR    4'd4
`define DEC_SGL_NOT    4'd5
`define DEC_SGL_CPY    4'd6
`define DEC_SGL_GSB    4'd7
`define DEC_SGL_CLS    4'd8
`define DEC_SGL_POP    4'd9
`define DEC_SGL_NOP    4'd10

`endif

//--- logic/decode_ctl_if.sv
// interface for middle register decode results, decoder to expander
`timescale 1ns/10ps
`include "dec_settings.svh"

interface decode_ctl_if;

	logic                      ok;            // legal opcode or thread event
	logic                      tst_hi;        // test from hi field
	logic                      tst_lo;        // test from lo field
	logic [2:0]                tst_hi_field;  // opcode[13:11]
	logic [2:0]                tst_lo_field;  // opcode[8:6]
	logic [`DEC_IM_DATA_W-1:0] im_field;      // raw immediate byte
	logic                      imda_6b;       // signed 6 bit data
	logic                      imda_8b;       // byte data
	logic                      imad;          // immediate address
	logic                      a_pop;
	logic                      b_pop;
	logic                      push;          // push onto a_sel stack
	logic [`DEC_STK_W-1:0]     a_sel;
	logic [`DEC_STK_W-1:0]     b_sel;

	modport dec_mp (
		output ok, tst_hi, tst_lo, tst_hi_field, tst_lo_field, im_field,
		output imda_6b, imda_8b, imad, a_pop, b_pop, push, a_sel, b_sel
	);

	modport exp_mp (
		input ok, tst_hi, tst_lo, tst_hi_field, tst_lo_field, im_field,
		input imda_6b, imda_8b, imad, a_pop, b_pop, push, a_sel, b_sel
	);

endinterface

//--- logic/op_class_decode.sv
// middle decode register, thread clear and interrupt priority, opcode classing
`timescale 1ns/10ps
`include "dec_settings.svh"

module op_class_decode (
	input  logic                   clk_i,
	input  logic                   rst_i,
	input  logic                   thrd_clr_i,    // thread clear
	input  logic                   thrd_intr_i,   // thread interrupt
	input  dec_pkg::op_word_u      op_code_i,
	decode_ctl_if.dec_mp           ctl_o,
	output logic                   pc_clr_o,      // pc clear
	output logic                   jmp_o,         // pc relative jump
	output logic                   gto_o,         // pc absolute goto
	output logic                   intr_o,        // pc to interrupt vector
	output logic                   stk_clr_o,     // clear all stacks
	output logic [`DEC_LG_W-1:0]   lg_o,          // logic op select
	output logic                   add_o,
	output logic                   sub_o,
	output logic                   cpy_o,         // copy b
	output logic                   rtn_o          // push return pc
);

	//////////////////////////////////////////////////////////////////////
	// immediate and test fields, taken every cycle
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_i or posedge rst_i) begin
		if (rst_i) begin
			ctl_o.tst_hi_field <= '0;
			ctl_o.tst_lo_field <= '0;
			ctl_o.im_field     <= '0;
		end else begin
			ctl_o.tst_hi_field <= op_code_i.imm.im[7:5];   // opcode[13:11]
			ctl_o.tst_lo_field <= op_code_i.imm.im[2:0];   // opcode[8:6]
			ctl_o.im_field     <= op_code_i.imm.im;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// control decode, clear beats interrupt beats opcode
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_i or posedge rst_i) begin
		if (rst_i) begin
			ctl_o.ok      <= 1'b0;
			ctl_o.tst_hi  <= 1'b0;
			ctl_o.tst_lo  <= 1'b0;
			ctl_o.imda_6b <= 1'b0;
			ctl_o.imda_8b <= 1'b0;
			ctl_o.imad    <= 1'b0;
			ctl_o.a_pop   <= 1'b0;
			ctl_o.b_pop   <= 1'b0;
			ctl_o.push    <= 1'b0;
			ctl_o.a_sel   <= '0;
			ctl_o.b_sel   <= '0;
			pc_clr_o      <= 1'b0;
			jmp_o         <= 1'b0;
			gto_o         <= 1'b0;
			intr_o        <= 1'b0;
			stk_clr_o     <= 1'b0;
			lg_o          <= '0;
			add_o         <= 1'b0;
			sub_o         <= 1'b0;
			cpy_o         <= 1'b0;
			rtn_o         <= 1'b0;
		end else begin
			ctl_o.ok      <= 1'b0;                     // illegal unless matched
			ctl_o.tst_hi  <= 1'b0;
			ctl_o.tst_lo  <= 1'b0;
			ctl_o.imda_6b <= 1'b0;
			ctl_o.imda_8b <= 1'b0;
			ctl_o.imad    <= 1'b0;
			ctl_o.a_pop   <= op_code_i.stk.a_pop;      // pops follow opcode
			ctl_o.b_pop   <= op_code_i.stk.b_pop;
			ctl_o.push    <= 1'b0;
			ctl_o.a_sel   <= op_code_i.stk.a_sel;      // selectors follow opcode
			ctl_o.b_sel   <= op_code_i.stk.b_sel;
			pc_clr_o      <= 1'b0;
			jmp_o         <= 1'b0;
			gto_o         <= 1'b0;
			intr_o        <= 1'b0;
			stk_clr_o     <= 1'b0;
			lg_o          <= '0;                       // and
			add_o         <= 1'b0;
			sub_o         <= 1'b0;
			cpy_o         <= 1'b0;
			rtn_o         <= 1'b0;
			if (thrd_clr_i) begin
				ctl_o.ok    <= 1'b1;
				pc_clr_o    <= 1'b1;
				stk_clr_o   <= 1'b1;
				ctl_o.a_pop <= 1'b0;
				ctl_o.b_pop <= 1'b0;
			end else if (thrd_intr_i) begin
				ctl_o.ok    <= 1'b1;
				intr_o      <= 1'b1;
				ctl_o.push  <= 1'b1;
				rtn_o       <= 1'b1;                   // return pc onto stack 0
				ctl_o.a_sel <= '0;
				ctl_o.a_pop <= 1'b0;
				ctl_o.b_pop <= 1'b0;
			end else begin
				casez (op_code_i.stk.op)
					`DEC_GRP_BYT : begin
						ctl_o.ok      <= 1'b1;
						ctl_o.push    <= 1'b1;
						ctl_o.imda_8b <= 1'b1;
						cpy_o         <= 1'b1;         // byte goes through copy
					end
					`DEC_GRP_JMPI : begin
						ctl_o.ok     <= 1'b1;
						jmp_o        <= 1'b1;
						ctl_o.imad   <= 1'b1;
						ctl_o.tst_hi <= 1'b1;
					end
					`DEC_GRP_ADDI : begin
						ctl_o.ok      <= 1'b1;
						ctl_o.push    <= 1'b1;
						ctl_o.imda_6b <= 1'b1;
						add_o         <= 1'b1;
					end
					`DEC_GRP_JMP : begin
						if (op_code_i.stk.op[2:0] != 3'b000) begin   // never-test is illegal
							ctl_o.ok     <= 1'b1;
							jmp_o        <= 1'b1;
							ctl_o.tst_lo <= 1'b1;
						end
					end
					`DEC_GRP_GTO : begin
						if (op_code_i.stk.op[2:0] != 3'b000) begin
							ctl_o.ok     <= 1'b1;
							gto_o        <= 1'b1;
							ctl_o.tst_lo <= 1'b1;
						end
					end
					`DEC_GRP_SGL : begin
						case (op_code_i.stk.op[3:0])
							`DEC_SGL_ADD : begin
								ctl_o.ok   <= 1'b1;
								ctl_o.push <= 1'b1;
								add_o      <= 1'b1;
							end
							`DEC_SGL_SUB : begin
								ctl_o.ok   <= 1'b1;
								ctl_o.push <= 1'b1;
								sub_o      <= 1'b1;
							end
							`DEC_SGL_AND : begin
								ctl_o.ok   <= 1'b1;
								ctl_o.push <= 1'b1;    // lg stays 0
							end
							`DEC_SGL_OR : begin
								ctl_o.ok   <= 1'b1;
								ctl_o.push <= 1'b1;
								lg_o       <= 2'd1;
							end
							`DEC_SGL_XOR : begin
								ctl_o.ok   <= 1'b1;
								ctl_o.push <= 1'b1;
								lg_o       <= 2'd2;
							end
							`DEC_SGL_NOT : begin
								ctl_o.ok   <= 1'b1;
								ctl_o.push <= 1'b1;
								lg_o       <= 2'd3;
							end
							`DEC_SGL_CPY : begin
								ctl_o.ok   <= 1'b1;
								ctl_o.push <= 1'b1;
								cpy_o      <= 1'b1;
							end
							`DEC_SGL_GSB : begin
								ctl_o.ok   <= 1'b1;
								ctl_o.push <= 1'b1;
								gto_o      <= 1'b1;
								rtn_o      <= 1'b1;    // subroutine return pc
							end
							`DEC_SGL_CLS : begin
								ctl_o.ok    <= 1'b1;
								stk_clr_o   <= 1'b1;
								ctl_o.a_pop <= 1'b0;
								ctl_o.b_pop <= 1'b0;
							end
							`DEC_SGL_POP : begin
								ctl_o.ok <= 1'b1;      // opcode pops only
							end
							`DEC_SGL_NOP : begin
								ctl_o.ok    <= 1'b1;
								ctl_o.a_pop <= 1'b0;
								ctl_o.b_pop <= 1'b0;
							end
							default : begin
								ctl_o.ok <= 1'b0;      // unused single
							end
						endcase
					end
					default : begin
						ctl_o.ok <= 1'b0;              // unused group
					end
				endcase
			end
		end
	end

endmodule

//--- logic/op_decode_top.sv
// opcode decoder top, input stage, decode register, expansion and output stage
`timescale 1ns/10ps
`include "dec_settings.svh"

module op_decode_top (
	input  logic                       clk_i,
	input  logic                       rst_i,
	input  logic                       thrd_clr_i,
	input  logic                       thrd_intr_i,
	input  logic [`DEC_OP_W-1:0]       op_code_i,
	output logic                       op_code_er_o,
	output logic [`DEC_IM_DATA_W-1:0]  im_data_o,
	output logic [`DEC_IM_ADDR_W-1:0]  im_addr_o,
	output logic                       pc_clr_o,
	output logic                       jmp_o,
	output logic                       gto_o,
	output logic                       intr_o,
	output logic                       tst_eq_o,
	output logic                       tst_lt_o,
	output logic                       tst_gt_o,
	output logic                       stk_clr_o,
	output logic [`DEC_STACKS-1:0]     pop_o,
	output logic [`DEC_STACKS-1:0]     push_o,
	output logic [`DEC_STK_W-1:0]      a_sel_o,
	output logic [`DEC_STK_W-1:0]      b_sel_o,
	output logic                       imda_o,
	output logic                       imad_o,
	output logic [`DEC_LG_W-1:0]       lg_o,
	output logic                       add_o,
	output logic                       sub_o,
	output logic                       cpy_o,
	output logic                       rtn_o
);

	localparam int IN_W  = 2 + `DEC_OP_W;
	localparam int OUT_W = 15 + `DEC_IM_ADDR_W + `DEC_IM_DATA_W + 2*`DEC_STACKS +
	                       2*`DEC_STK_W + `DEC_LG_W;   // 14 strobes plus error flag

	logic                      thrd_clr, thrd_intr;
	logic [`DEC_OP_W-1:0]      op_code;
	logic                      op_code_er, pc_clr, jmp, gto, intr, stk_clr;
	logic                      tst_eq, tst_lt, tst_gt, imda, imad, add, sub, cpy, rtn;
	logic [`DEC_IM_DATA_W-1:0] im_data;
	logic [`DEC_IM_ADDR_W-1:0] im_addr;
	logic [`DEC_STACKS-1:0]    pop, push;
	logic [`DEC_STK_W-1:0]     a_sel, b_sel;
	logic [`DEC_LG_W-1:0]      lg;

	decode_ctl_if ctl_if ();

	pipe_regs #(.REGS(`DEC_REGS_IN), .DATA_W(IN_W)) in_regs (
		.clk_i  (clk_i),
		.rst_i  (rst_i),
		.data_i ({thrd_clr_i, thrd_intr_i, op_code_i}),
		.data_o ({thrd_clr, thrd_intr, op_code})
	);

	op_class_decode u_class (
		.clk_i       (clk_i),
		.rst_i       (rst_i),
		.thrd_clr_i  (thrd_clr),
		.thrd_intr_i (thrd_intr),
		.op_code_i   (op_code),
		.ctl_o       (ctl_if),
		.pc_clr_o    (pc_clr),
		.jmp_o       (jmp),
		.gto_o       (gto),
		.intr_o      (intr),
		.stk_clr_o   (stk_clr),
		.lg_o        (lg),
		.add_o       (add),
		.sub_o       (sub),
		.cpy_o       (cpy),
		.rtn_o       (rtn)
	);

	op_expand u_expand (
		.ctl_i        (ctl_if),
		.tst_eq_o     (tst_eq),
		.tst_lt_o     (tst_lt),
		.tst_gt_o     (tst_gt),
		.im_data_o    (im_data),
		.im_addr_o    (im_addr),
		.pop_o        (pop),
		.push_o       (push),
		.imda_o       (imda),
		.imad_o       (imad),
		.a_sel_o      (a_sel),
		.b_sel_o      (b_sel),
		.op_code_er_o (op_code_er)
	);

	pipe_regs #(.REGS(`DEC_REGS_OUT), .DATA_W(OUT_W)) out_regs (
		.clk_i  (clk_i),
		.rst_i  (rst_i),
		.data_i ({op_code_er, im_addr, im_data, pc_clr, intr, gto, jmp,
		          tst_gt, tst_lt, tst_eq, stk_clr, pop, push, a_sel, b_sel,
		          imda, imad, rtn, cpy, sub, add, lg}),
		.data_o ({op_code_er_o, im_addr_o, im_data_o, pc_clr_o, intr_o, gto_o, jmp_o,
		          tst_gt_o, tst_lt_o, tst_eq_o, stk_clr_o, pop_o, push_o, a_sel_o, b_sel_o,
		          imda_o, imad_o, rtn_o, cpy_o, sub_o, add_o, lg_o})
	);

endmodule

//--- logic/op_expand.sv
// expansion of test flags, immediates, stack masks and error flag
`timescale 1ns/10ps
`include "dec_settings.svh"

module op_expand (
	decode_ctl_if.exp_mp               ctl_i,
	output logic                       tst_eq_o,
	output logic                       tst_lt_o,
	output logic                       tst_gt_o,
	output logic [`DEC_IM_DATA_W-1:0]  im_data_o,
	output logic [`DEC_IM_ADDR_W-1:0]  im_addr_o,
	output logic [`DEC_STACKS-1:0]     pop_o,
	output logic [`DEC_STACKS-1:0]     push_o,
	output logic                       imda_o,
	output logic                       imad_o,
	output logic [`DEC_STK_W-1:0]      a_sel_o,
	output logic [`DEC_STK_W-1:0]      b_sel_o,
	output logic                       op_code_er_o
);

	localparam int STK_W = `DEC_STK_W;

	// hi field wins, no test means always
	always_comb begin
		if (ctl_i.tst_hi) begin
			{tst_gt_o, tst_lt_o, tst_eq_o} = ctl_i.tst_hi_field;
		end else if (ctl_i.tst_lo) begin
			{tst_gt_o, tst_lt_o, tst_eq_o} = ctl_i.tst_lo_field;
		end else begin
			{tst_gt_o, tst_lt_o, tst_eq_o} = 3'b111;
		end
	end

	assign im_data_o = ctl_i.imda_6b ?
		{{(`DEC_IM_DATA_W-6){ctl_i.im_field[5]}}, ctl_i.im_field[5:0]} :   // sign extend
		ctl_i.im_field;
	assign im_addr_o = ctl_i.im_field[`DEC_IM_ADDR_W-1:0];   // jump offset

	// one hot per stack, a and b may hit the same stack
	always_comb begin
		for (int i = 0; i < `DEC_STACKS; i++) begin
			pop_o[i]  = ctl_i.ok &&   // illegal opcode pops nothing
			            ((ctl_i.a_pop && (ctl_i.a_sel == STK_W'(i))) ||
			             (ctl_i.b_pop && (ctl_i.b_sel == STK_W'(i))));
			push_o[i] = ctl_i.push && (ctl_i.a_sel == STK_W'(i));
		end
	end

	assign imda_o       = ctl_i.imda_6b | ctl_i.imda_8b;
	assign imad_o       = ctl_i.imad;
	assign a_sel_o      = ctl_i.a_sel;
	assign b_sel_o      = ctl_i.b_sel;
	assign op_code_er_o = ~ctl_i.ok;   // nothing matched

endmodule

//--- logic/pipe_regs.sv
// parameterized register chain with asynchronous clear, zero stages is a wire
`timescale 1ns/10ps

module pipe_regs #(
	parameter int REGS   = 1,   // stage count
	parameter int DATA_W = 8    // vector width
) (
	input  logic              clk_i,
	input  logic              rst_i,
	input  logic [DATA_W-1:0] data_i,
	output logic [DATA_W-1:0] data_o
);

	generate
		if (REGS == 0) begin : g_wire
			assign data_o = data_i;   // no registering
		end else begin : g_regs
			logic [DATA_W-1:0] stage_r [REGS];   // stage 0 is nearest the input

			always_ff @(posedge clk_i or posedge rst_i) begin
				if (rst_i) begin
					for (int i = 0; i < REGS; i++) begin
						stage_r[i] <= '0;
					end
				end else begin
					stage_r[0] <= data_i;
					for (int i = 1; i < REGS; i++) begin
						stage_r[i] <= stage_r[i-1];   // shift down the chain
					end
				end
			end

			assign data_o = stage_r[REGS-1];
		end
	endgenerate

endmodule

//--- project.f
+incdir+logic
logic/dec_pkg.sv
logic/decode_ctl_if.sv
logic/pipe_regs.sv
logic/op_class_decode.sv
logic/op_expand.sv
logic/op_decode_top.sv
verif/tb_clock_gen.sv
verif/op_decode_checker.sv
verif/op_decode_tb.sv

//--- verif/op_decode_checker.sv
// concurrent assertions on decoder output strobes, masks and reset state
`timescale 1ns/10ps
`include "dec_settings.svh"

module op_decode_checker (
	input logic                   clk_i,
	input logic                   rst_i,
	input logic                   op_code_er_i,
	input logic                   pc_clr_i,
	input logic                   jmp_i,
	input logic                   gto_i,
	input logic                   intr_i,
	input logic                   stk_clr_i,
	input logic [`DEC_STACKS-1:0] pop_i,
	input logic [`DEC_STACKS-1:0] push_i,
	input logic                   imda_i,
	input logic                   imad_i,
	input logic [`DEC_LG_W-1:0]   lg_i,
	input logic                   add_i,
	input logic                   sub_i,
	input logic                   cpy_i,
	input logic                   rtn_i
);

	int         fail_cnt = 0;   // read by the testbench at the end
	logic [11:0] strobes;

	assign strobes = {pc_clr_i, jmp_i, gto_i, intr_i, stk_clr_i, imda_i, imad_i,
	                  |lg_i, add_i, sub_i, cpy_i, rtn_i};

	// one pc action per cycle
	a_pc_excl: assert property (@(posedge clk_i) disable iff (rst_i)
		$onehot0({pc_clr_i, jmp_i, gto_i, intr_i}))
		else begin fail_cnt++; $error("more than one pc strobe high"); end

	a_push_one: assert property (@(posedge clk_i) disable iff (rst_i)
		$onehot0(push_i))
		else begin fail_cnt++; $error("push mask has several bits set"); end

	// illegal opcode moves nothing
	a_err_quiet: assert property (@(posedge clk_i) disable iff (rst_i)
		op_code_er_i |-> (push_i == '0 && pop_i == '0 && strobes == '0))
		else begin fail_cnt++; $error("push, pop or strobe with illegal opcode"); end

	a_rst_quiet: assert property (@(posedge clk_i)
		rst_i |-> (strobes == '0 && pop_i == '0 && push_i == '0))
		else begin fail_cnt++; $error("strobe active during reset"); end

endmodule

//--- verif/op_decode_tb.sv
// opcode decoder testbench, random stimulus, reference model, compare tasks, watchdog
`timescale 1ns/10ps
`include "dec_settings.svh"

module op_decode_tb #(
	parameter int SEED = 32'h67e1ed88
);

	localparam int CLK_PERIOD  = 100;
	localparam int RST_CYCLES  = 8;
	localparam int DRV_DLY     = 10;                                  // after rising edge
	localparam int LAT         = `DEC_REGS_IN + 1 + `DEC_REGS_OUT;   // input to output
	localparam int N_THR       = 16;
	localparam int N_IMM       = 16;
	localparam int N_JMP       = 24;
	localparam int N_SGL       = 4;    // per single code
	localparam int N_SGL_CODES = 11;
	localparam int N_ILL       = 32;
	localparam int N_MIX       = 64;
	localparam int TOTAL_CYCLES = RST_CYCLES + 1 + LAT + 2*N_THR + 3*N_IMM + N_JMP +
	                              N_SGL_CODES*N_SGL + N_ILL + N_MIX + 6*LAT;
	localparam int WATCHDOG_NS  = (TOTAL_CYCLES + 20) * CLK_PERIOD;

	typedef struct packed {
		logic                      er;
		logic [`DEC_IM_DATA_W-1:0] im_data;
		logic [`DEC_IM_ADDR_W-1:0] im_addr;
		logic                      pc_clr, jmp, gto, intr;
		logic                      tst_eq, tst_lt, tst_gt;
		logic                      stk_clr;
		logic [`DEC_STACKS-1:0]    pop, push;
		logic [`DEC_STK_W-1:0]     a_sel, b_sel;
		logic                      imda, imad;
		logic [`DEC_LG_W-1:0]      lg;
		logic                      add, sub, cpy, rtn;
	} exp_t;

	logic                      clk, rst;
	logic                      thrd_clr, thrd_intr;
	logic [`DEC_OP_W-1:0]      op_code;
	logic                      op_code_er, pc_clr, jmp, gto, intr, stk_clr;
	logic                      tst_eq, tst_lt, tst_gt, imda, imad, add, sub, cpy, rtn;
	logic [`DEC_IM_DATA_W-1:0] im_data;
	logic [`DEC_IM_ADDR_W-1:0] im_addr;
	logic [`DEC_STACKS-1:0]    pop, push;
	logic [`DEC_STK_W-1:0]     a_sel, b_sel;
	logic [`DEC_LG_W-1:0]      lg;

	int    seed;
	int    n_tests  = 0;
	int    n_checks = 0;
	int    n_errors = 0;
	int    chk_mark, err_mark;   // counts at test start
	string cur_test;
	exp_t  exp_q[$];             // opcodes in flight

	tb_clock_gen #(.PERIOD(CLK_PERIOD), .RST_CYCLES(RST_CYCLES)) clk_gen (
		.clk_o (clk),
		.rst_o (rst)
	);

	op_decode_top dut_i (
		.clk_i (clk), .rst_i (rst), .thrd_clr_i (thrd_clr), .thrd_intr_i (thrd_intr),
		.op_code_i (op_code), .op_code_er_o (op_code_er), .im_data_o (im_data),
		.im_addr_o (im_addr), .pc_clr_o (pc_clr), .jmp_o (jmp), .gto_o (gto),
		.intr_o (intr), .tst_eq_o (tst_eq), .tst_lt_o (tst_lt), .tst_gt_o (tst_gt),
		.stk_clr_o (stk_clr), .pop_o (pop), .push_o (push), .a_sel_o (a_sel),
		.b_sel_o (b_sel), .imda_o (imda), .imad_o (imad), .lg_o (lg), .add_o (add),
		.sub_o (sub), .cpy_o (cpy), .rtn_o (rtn)
	);

	bind op_decode_top op_decode_checker u_chk (
		.clk_i (clk_i), .rst_i (rst_i), .op_code_er_i (op_code_er_o), .pc_clr_i (pc_clr_o),
		.jmp_i (jmp_o), .gto_i (gto_o), .intr_i (intr_o), .stk_clr_i (stk_clr_o),
		.pop_i (pop_o), .push_i (push_o), .imda_i (imda_o), .imad_i (imad_o),
		.lg_i (lg_o), .add_i (add_o), .sub_i (sub_o), .cpy_i (cpy_o), .rtn_i (rtn_o)
	);

	//////////////////////////////////////////////////////////////////////
	// reference model
	//////////////////////////////////////////////////////////////////////

	function automatic exp_t model(input logic clr, input logic intr_ev,
	                               input dec_pkg::op_word_u w);
		exp_t                  e;
		logic [`DEC_OP_W-1:0]  raw;
		logic [`DEC_OPF_W-1:0] op;
		logic [3:0]            sgl;
		logic                  ok, tst_hi, tst_lo, imda6, imda8, push_b, a_pop, b_pop;
		logic [`DEC_STK_W-1:0] a_s;
		e      = '0;
		raw    = w;
		op     = w.stk.op;
		sgl    = op[3:0];
		ok     = 1'b0;
		tst_hi = 1'b0;
		tst_lo = 1'b0;
		imda6  = 1'b0;
		imda8  = 1'b0;
		push_b = 1'b0;
		a_pop  = w.stk.a_pop;
		b_pop  = w.stk.b_pop;
		a_s    = w.stk.a_sel;
		if (clr) begin                        // clear beats all
			ok        = 1'b1;
			e.pc_clr  = 1'b1;
			e.stk_clr = 1'b1;
			a_pop     = 1'b0;
			b_pop     = 1'b0;
		end else if (intr_ev) begin
			ok     = 1'b1;
			e.intr = 1'b1;
			e.rtn  = 1'b1;
			push_b = 1'b1;
			a_s    = '0;                      // return pc to stack 0
			a_pop  = 1'b0;
			b_pop  = 1'b0;
		end else if (op[9:8] == 2'b01) begin  // byte
			ok     = 1'b1;
			push_b = 1'b1;
			imda8  = 1'b1;
			e.cpy  = 1'b1;
		end else if (op[9:8] == 2'b10) begin  // jump immediate
			ok     = 1'b1;
			e.jmp  = 1'b1;
			e.imad = 1'b1;
			tst_hi = 1'b1;
		end else if (op[9:6] == 4'b1100) begin
			ok     = 1'b1;
			push_b = 1'b1;
			imda6  = 1'b1;
			e.add  = 1'b1;
		end else if (op[9:4] == 6'b111000 && op[2:0] != 3'b000) begin
			ok     = 1'b1;                    // op[3] picks goto over jump
			tst_lo = 1'b1;
			e.jmp  = ~op[3];
			e.gto  = op[3];
		end else if (op[9:4] == 6'b111100) begin
			ok        = (sgl <= `DEC_SGL_NOP);
			push_b    = (sgl <= `DEC_SGL_GSB);   // add through gsb push
			e.add     = (sgl == `DEC_SGL_ADD);
			e.sub     = (sgl == `DEC_SGL_SUB);
			e.cpy     = (sgl == `DEC_SGL_CPY);
			e.gto     = (sgl == `DEC_SGL_GSB);
			e.rtn     = (sgl == `DEC_SGL_GSB);
			e.stk_clr = (sgl == `DEC_SGL_CLS);
			if (sgl >= `DEC_SGL_AND && sgl <= `DEC_SGL_NOT) begin
				e.lg = `DEC_LG_W'(sgl - `DEC_SGL_AND);
			end
			if (sgl == `DEC_SGL_CLS || sgl == `DEC_SGL_NOP) begin
				a_pop = 1'b0;
				b_pop = 1'b0;
			end
		end
		if (!ok) begin                        // illegal opcode pops nothing
			a_pop = 1'b0;
			b_pop = 1'b0;
		end
		if (tst_hi) begin
			{e.tst_gt, e.tst_lt, e.tst_eq} = raw[13:11];
		end else if (tst_lo) begin
			{e.tst_gt, e.tst_lt, e.tst_eq} = raw[8:6];
		end else begin
			{e.tst_gt, e.tst_lt, e.tst_eq} = 3'b111;   // always
		end
		e.im_data = imda6 ? `DEC_IM_DATA_W'($signed(raw[11:6])) : raw[13:6];
		e.im_addr = raw[6 +: `DEC_IM_ADDR_W];
		if (a_pop) e.pop[a_s] = 1'b1;
		if (b_pop) e.pop[w.stk.b_sel] = 1'b1;
		if (push_b) e.push[a_s] = 1'b1;
		e.a_sel = a_s;
		e.b_sel = w.stk.b_sel;
		e.imda  = imda6 | imda8;
		e.er    = ~ok;
		return e;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// compare tasks
	//////////////////////////////////////////////////////////////////////

	task automatic flag_mismatch(input string sig, input logic [31:0] exp, act);
		n_errors++;
		$display("CHECK FAILED %s %s: expected %0h, actual %0h", cur_test, sig, exp, act);
	endtask

	task automatic check_bit(input string sig, input logic exp, act);
		n_checks++;
		if (exp !== act) flag_mismatch(sig, 32'(exp), 32'(act));
	endtask

	task automatic check_mask(input string sig, input logic [`DEC_STACKS-1:0] exp, act);
		n_checks++;
		if (exp !== act) flag_mismatch(sig, 32'(exp), 32'(act));
	endtask

	task automatic check_data(input string sig, input logic [`DEC_IM_DATA_W-1:0] exp, act);
		n_checks++;
		if (exp !== act) flag_mismatch(sig, 32'(exp), 32'(act));
	endtask

	task automatic check_addr(input string sig, input logic [`DEC_IM_ADDR_W-1:0] exp, act);
		n_checks++;
		if (exp !== act) flag_mismatch(sig, 32'(exp), 32'(act));
	endtask

	task automatic check_sel(input string sig, input logic [`DEC_STK_W-1:0] exp, act);
		n_checks++;
		if (exp !== act) flag_mismatch(sig, 32'(exp), 32'(act));
	endtask

	task automatic check_lg(input string sig, input logic [`DEC_LG_W-1:0] exp, act);
		n_checks++;
		if (exp !== act) flag_mismatch(sig, 32'(exp), 32'(act));
	endtask

	task automatic compare_outputs(input exp_t e);
		check_bit("op_code_er", e.er, op_code_er);
		check_data("im_data", e.im_data, im_data);
		check_addr("im_addr", e.im_addr, im_addr);
		check_bit("pc_clr", e.pc_clr, pc_clr);
		check_bit("jmp", e.jmp, jmp);
		check_bit("gto", e.gto, gto);
		check_bit("intr", e.intr, intr);
		check_bit("tst_eq", e.tst_eq, tst_eq);
		check_bit("tst_lt", e.tst_lt, tst_lt);
		check_bit("tst_gt", e.tst_gt, tst_gt);
		check_bit("stk_clr", e.stk_clr, stk_clr);
		check_mask("pop", e.pop, pop);
		check_mask("push", e.push, push);
		check_sel("a_sel", e.a_sel, a_sel);
		check_sel("b_sel", e.b_sel, b_sel);
		check_bit("imda", e.imda, imda);
		check_bit("imad", e.imad, imad);
		check_lg("lg", e.lg, lg);
		check_bit("add", e.add, add);
		check_bit("sub", e.sub, sub);
		check_bit("cpy", e.cpy, cpy);
		check_bit("rtn", e.rtn, rtn);
	endtask

	//////////////////////////////////////////////////////////////////////
	// stimulus
	//////////////////////////////////////////////////////////////////////

	// one opcode per cycle, oldest expectation checked as it leaves the pipe
	task automatic step(input logic clr, input logic intr_ev, input logic [`DEC_OP_W-1:0] op);
		@(posedge clk);
		#DRV_DLY;
		if (exp_q.size() == LAT) compare_outputs(exp_q.pop_front());
		thrd_clr  = clr;
		thrd_intr = intr_ev;
		op_code   = op;
		exp_q.push_back(model(clr, intr_ev, op));
	endtask

	task automatic drain();
		while (exp_q.size() > 0) begin
			@(posedge clk);
			#DRV_DLY;
			compare_outputs(exp_q.pop_front());
			thrd_clr  = 1'b0;
			thrd_intr = 1'b0;
			op_code   = '0;
		end
	endtask

	task automatic test_begin(input string name);
		cur_test = name;
		chk_mark = n_checks;
		err_mark = n_errors;
		n_tests++;
	endtask

	task automatic test_end();
		drain();
		$display("test %s done: %0d checks, %0d errors", cur_test,
		         n_checks - chk_mark, n_errors - err_mark);
	endtask

	task automatic reset_test();
		test_begin("reset");
		@(posedge rst);
		repeat (4) begin
			@(posedge clk);
			#DRV_DLY;
			compare_outputs('0);               // all registers cleared
		end
		@(negedge rst);
		repeat (LAT) begin
			@(posedge clk);
			#DRV_DLY;
			compare_outputs(model(1'b0, 1'b0, '0));   // zeroed decode, no strobes
		end
		test_end();
	endtask

	task automatic thread_test();
		logic [31:0] r;
		test_begin("thread");
		for (int i = 0; i < N_THR; i++) begin
			r = $random(seed);
			step(1'b1, r[16], r[15:0]);        // clear wins over both
		end
		for (int i = 0; i < N_THR; i++) begin
			r = $random(seed);
			step(1'b0, 1'b1, r[15:0]);
		end
		test_end();
	endtask

	task automatic imm_test();
		logic [31:0] r;
		test_begin("immediate");
		for (int i = 0; i < N_IMM; i++) begin
			r = $random(seed);
			step(1'b0, 1'b0, {2'b01, r[13:0]});
			step(1'b0, 1'b0, {2'b10, r[29:16]});
			r = $random(seed);
			step(1'b0, 1'b0, {4'b1100, r[11:0]});
		end
		test_end();
	endtask

	task automatic reg_jump_test();
		logic [31:0] r;
		logic [2:0]  tc;
		logic        kind;
		test_begin("reg_jump");
		for (int i = 0; i < N_JMP; i++) begin
			r    = $random(seed);
			tc   = (i < 2) ? 3'b000 : r[18:16];   // never-test first
			kind = (i < 2) ? i[0] : r[20];
			step(1'b0, 1'b0, {6'b111000, kind, tc, r[5:0]});
		end
		test_end();
	endtask

	task automatic singles_test();
		logic [31:0] r;
		test_begin("singles");
		for (int c = 0; c < N_SGL_CODES; c++) begin
			for (int k = 0; k < N_SGL; k++) begin
				r = $random(seed);
				step(1'b0, 1'b0, {6'b111100, c[3:0], r[5:0]});
			end
		end
		test_end();
	endtask

	task automatic illegal_test();
		logic [31:0]          r;
		logic [`DEC_OP_W-1:0] w;
		test_begin("illegal");
		for (int i = 0; i < N_ILL; i++) begin
			r = $random(seed);
			case (r[18:16])
				3'd0, 3'd1 : w = {2'b00, r[13:0]};
				3'd2       : w = {4'b1101, r[11:0]};
				3'd3       : w = {6'b111100, 2'b11, r[7:0]};        // codes 12 to 15
				3'd4       : w = {6'b111100, 4'd11, r[5:0]};
				3'd5       : w = {6'b111000, r[9], 3'b000, r[5:0]};
				3'd6       : w = {5'b11111, r[10:0]};
				default    : w = {6'b111010, r[9:0]};
			endcase
			step(1'b0, 1'b0, w);
		end
		test_end();
	endtask

	task automatic mix_test();
		logic [31:0] r;
		test_begin("mix");
		for (int i = 0; i < N_MIX; i++) begin
			r = $random(seed);
			step(r[20:16] == 5'd0, r[25:21] == 5'd0, r[15:0]);   // rare thread events
		end
		test_end();
	endtask

	initial begin
		seed      = SEED;
		thrd_clr  = 1'b0;
		thrd_intr = 1'b0;
		op_code   = '0;
		reset_test();
		thread_test();
		imm_test();
		reg_jump_test();
		singles_test();
		illegal_test();
		mix_test();
		if (dut_i.u_chk.fail_cnt != 0) begin
			$display("checker reported %0d assertion failures", dut_i.u_chk.fail_cnt);
			n_errors += dut_i.u_chk.fail_cnt;
		end
		$display("summary: %0d tests, %0d checks, %0d errors", n_tests, n_checks, n_errors);
		if (n_errors == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

	// watchdog
	initial begin
		#(WATCHDOG_NS);
		$display("timeout: tests did not finish within %0d ns", WATCHDOG_NS);
		$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

//--- verif/tb_clock_gen.sv
// testbench clock source and power on reset
`timescale 1ns/10ps

module tb_clock_gen #(
	parameter int PERIOD     = 100,   // ns
	parameter int RST_CYCLES = 8      // rising edges held in reset
) (
	output logic clk_o,
	output logic rst_o
);

	initial begin
		clk_o = 1'b0;
		forever #(PERIOD/2) clk_o = ~clk_o;
	end

	initial begin
		rst_o = 1'b0;
		#5 rst_o = 1'b1;                      // edge clears the async registers
		repeat (RST_CYCLES) @(posedge clk_o);
		#10 rst_o = 1'b0;                     // release off the clock edge
	end

endmodule
